// ==== include/glyph_consts.svh ====
// glyph plotter constants for screen geometry, pacing and random source
`ifndef GLYPH_CONSTS_SVH
`define GLYPH_CONSTS_SVH

// screen coordinate widths, 160x120 frame
`define X_W 8
`define Y_W 7
`define COLOUR_W 3

// every glyph is walked from this point
`define ORIGIN_X 79
`define ORIGIN_Y 63

// clocks between two plot points
`define GLYPH_STEP_CYCLES 4

// random source
`define RAND_W 4
`define RAND_SEED 4'b1110 // nonzero so the lfsr never locks up

// longest glyph is R with eight strokes
`define MAX_SEG 8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the glyph plotter testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module glyph_tb -f sources.f -o glyph_sim

./obj_dir/glyph_sim

// ==== sources.f ====
+incdir+include
src/glyph_pkg.sv
src/ctrl_pkg.sv
src/draw_cmd_if.sv
src/instruction_picker.sv
src/glyph_sequencer.sv
src/glyph_plotter.sv
src/glyph_top.sv
verif/glyph_tb.sv

// ==== src/ctrl_pkg.sv ====
// control types for the draw and erase sequencing

package ctrl_pkg;

	// IDLE   waiting for a change strobe
	// ARMED  strobe seen, waiting for it to fall
	// DRAW   plotter busy with a coloured glyph
	// ERASE  plotter busy painting the last glyph black
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		ARMED = 2'b01,
		DRAW  = 2'b10,
		ERASE = 2'b11
	} seq_state_e;

endpackage

// ==== src/draw_cmd_if.sv ====
// draw command link between the sequencer and the plotter
`timescale 1ns/10ps

interface draw_cmd_if;

	logic               start; // one cycle pulse
	glyph_pkg::glyph_e  shape; // valid with start
	logic               erase; // valid with start
	logic               done;  // one cycle after the last point

	modport seq (
		output start,
		output shape,
		output erase,
		input  done
	);

	modport plot (
		input  start,
		input  shape,
		input  erase,
		output done
	);

endinterface

// ==== src/glyph_pkg.sv ====
// glyph types shared by the picker, sequencer and plotter
`include "glyph_consts.svh"

package glyph_pkg;

	// shape codes, same numbering as the old instruction bus
	typedef enum logic [2:0] {
		UP    = 3'b000,
		DOWN  = 3'b001,
		RIGHT = 3'b010,
		LEFT  = 3'b011,
		R     = 3'b100,
		L     = 3'b101
	} glyph_e;

	// rgb, one bit per channel
	typedef logic [`COLOUR_W-1:0] colour_t;

	// one straight stroke of a glyph
	typedef struct packed {
		logic signed [3:0] off_x;  // start relative to origin
		logic signed [3:0] off_y;
		logic signed [1:0] step_x; // -1, 0 or +1 per point
		logic signed [1:0] step_y;
		logic        [2:0] len;    // point count minus one
	} seg_t;

endpackage

// ==== src/glyph_plotter.sv ====
// glyph plotter, walks the stroke table of a shape at a fixed point rate
`timescale 1ns/10ps
`include "glyph_consts.svh"

module glyph_plotter (
	input  logic                clk,
	input  logic                reset_n,
	draw_cmd_if.plot            cmd,
	output logic [`X_W-1:0]     x,
	output logic [`Y_W-1:0]     y,
	output glyph_pkg::colour_t  colour,
	output logic                plot
);

	localparam int DIV_W = $clog2(`GLYPH_STEP_CYCLES + 1);
	localparam int SEG_W = $clog2(`MAX_SEG);

	logic                busy;
	logic                done_q;
	logic [DIV_W-1:0]    div;
	logic [SEG_W-1:0]    seg_idx;
	logic [2:0]          pt_idx;
	glyph_pkg::glyph_e   shape_q;
	logic                erase_q;
	glyph_pkg::seg_t     cur_seg;
	logic                step_hit;
	logic                last_pt;
	logic                last_seg;
	logic signed [4:0]   dx;
	logic signed [4:0]   dy;

	function automatic glyph_pkg::seg_t mk_seg(input int ox, input int oy,
			input int sx, input int sy, input int count);
		glyph_pkg::seg_t s;
		s.off_x  = 4'(ox);
		s.off_y  = 4'(oy);
		s.step_x = 2'(sx);
		s.step_y = 2'(sy);
		s.len    = 3'(count - 1);
		return s;
	endfunction

	// stroke table, y grows downwards on screen
	function automatic glyph_pkg::seg_t seg_of(input glyph_pkg::glyph_e shape,
			input logic [SEG_W-1:0] idx);
		glyph_pkg::seg_t s;
		s = mk_seg(0, 0, 0, 0, 1);
		case (shape)
			glyph_pkg::UP, glyph_pkg::DOWN:
				case (idx)
					0: s = mk_seg(0, 0, 0, 1, 8);  // shaft
					1: s = mk_seg(0, 0, 1, 1, 4);
					2: s = mk_seg(0, 0, -1, 1, 4);
					default: ;
				endcase
			glyph_pkg::RIGHT:
				case (idx)
					0: s = mk_seg(0, 0, -1, 0, 8);
					1: s = mk_seg(0, 0, -1, -1, 4);
					2: s = mk_seg(0, 0, -1, 1, 4);
					default: ;
				endcase
			glyph_pkg::LEFT:
				case (idx)
					0: s = mk_seg(0, 0, 1, 0, 8);
					1: s = mk_seg(0, 0, 1, -1, 4);
					2: s = mk_seg(0, 0, 1, 1, 4);
					default: ;
				endcase
			glyph_pkg::L:
				case (idx)
					0: s = mk_seg(0, 0, 0, -1, 8);
					1: s = mk_seg(0, 0, 1, 0, 4);
					default: ;
				endcase
			glyph_pkg::R:
				case (idx)
					0: s = mk_seg(0, 0, 1, 0, 4);   // top of the bowl
					1: s = mk_seg(2, 0, 1, 1, 3);
					2: s = mk_seg(3, 1, 0, 1, 4);
					3: s = mk_seg(3, 3, -1, 1, 3);
					4: s = mk_seg(2, 4, -1, 0, 4);
					5: s = mk_seg(0, 0, 0, 1, 5);   // stem
					6: s = mk_seg(0, 4, 0, 1, 5);
					7: s = mk_seg(0, 4, 1, 1, 5);   // leg
					default: ;
				endcase
			default: ;
		endcase
		return s;
	endfunction

	function automatic logic [SEG_W-1:0] last_seg_of(input glyph_pkg::glyph_e shape);
		case (shape)
			glyph_pkg::L: return SEG_W'(1);
			glyph_pkg::R: return SEG_W'(7);
			default:      return SEG_W'(2);
		endcase
	endfunction

	function automatic glyph_pkg::colour_t colour_of(input glyph_pkg::glyph_e shape);
		case (shape)
			glyph_pkg::UP:    return 3'b111;
			glyph_pkg::DOWN:  return 3'b001;
			glyph_pkg::RIGHT: return 3'b011;
			glyph_pkg::LEFT:  return 3'b010;
			glyph_pkg::L:     return 3'b101;
			default:          return 3'b100;
		endcase
	endfunction

	// distance walked along one axis, step is -1, 0 or +1
	function automatic logic signed [4:0] walk(input logic signed [1:0] step,
			input logic [2:0] pt);
		logic signed [4:0] d;
		d = signed'({2'b00, pt});
		case (step)
			2'sb01:  return d;
			2'sb11:  return -d;
			default: return 5'sd0;
		endcase
	endfunction

	assign cur_seg  = seg_of(shape_q, seg_idx);
	assign step_hit = (div == DIV_W'(`GLYPH_STEP_CYCLES - 1));
	assign last_pt  = (pt_idx == cur_seg.len);
	assign last_seg = (seg_idx == last_seg_of(shape_q));

	assign dx = 5'(cur_seg.off_x) + walk(cur_seg.step_x, pt_idx);
	assign dy = 5'(cur_seg.off_y) + walk(cur_seg.step_y, pt_idx);

	assign x        = `X_W'(`ORIGIN_X) + `X_W'(dx);
	assign y        = `Y_W'(`ORIGIN_Y) + `Y_W'(dy);
	assign colour   = erase_q ? 3'b000 : colour_of(shape_q); // black paints over
	assign plot     = busy & step_hit;
	assign cmd.done = done_q;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			busy    <= 1'b0;
			done_q  <= 1'b0;
			div     <= '0;
			seg_idx <= '0;
			pt_idx  <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (!busy)
			begin
				if (cmd.start)
				begin
					busy    <= 1'b1;
					div     <= '0;
					seg_idx <= '0;
					pt_idx  <= '0;
				end
			end
			else if (step_hit)
			begin
				div <= '0;
				if (!last_pt)
					pt_idx <= pt_idx + 3'd1;
				else
				begin
					pt_idx <= '0;
					if (last_seg)
					begin
						busy   <= 1'b0;
						done_q <= 1'b1;
					end
					else
						seg_idx <= seg_idx + SEG_W'(1);
				end
			end
			else
				div <= div + DIV_W'(1);
		end
	end

	// command latched for the whole glyph
	always_ff @(posedge clk)
	begin
		if (!busy && cmd.start)
		begin
			shape_q <= cmd.shape;
			erase_q <= cmd.erase;
		end
	end

endmodule

// ==== src/glyph_sequencer.sv ====
// glyph sequencer, arms on the change strobe and draws or erases on its fall
`timescale 1ns/10ps

module glyph_sequencer (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              change_instruction,
	input  logic              clear_instruction,
	input  glyph_pkg::glyph_e shape_now,
	draw_cmd_if.seq           cmd
);

	ctrl_pkg::seq_state_e state;
	ctrl_pkg::seq_state_e state_next;
	logic                 erase_flag;  // clear seen while armed
	logic                 strobe_seen; // change went high while waiting
	logic                 erase_sel;
	logic                 issue;
	glyph_pkg::glyph_e    last_shape;  // shape of the last coloured draw

	assign erase_sel = erase_flag | clear_instruction;
	assign issue     = (state == ctrl_pkg::ARMED) && strobe_seen && !change_instruction;

	assign cmd.start = issue;
	assign cmd.erase = erase_sel;
	assign cmd.shape = erase_sel ? last_shape : shape_now; // erase repaints the old glyph

	always_comb
	begin
		state_next = state;
		case (state)
			ctrl_pkg::IDLE:
				if (change_instruction)
					state_next = ctrl_pkg::ARMED;
			ctrl_pkg::ARMED:
				if (issue)
					state_next = erase_sel ? ctrl_pkg::ERASE : ctrl_pkg::DRAW;
			ctrl_pkg::DRAW:
				if (cmd.done)
					state_next = ctrl_pkg::ARMED;
			ctrl_pkg::ERASE:
				if (cmd.done)
					state_next = ctrl_pkg::IDLE;
			default:
				state_next = ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state       <= ctrl_pkg::IDLE;
			erase_flag  <= 1'b0;
			strobe_seen <= 1'b0;
			last_shape  <= glyph_pkg::UP;
		end
		else
		begin
			state <= state_next;
			case (state)
				ctrl_pkg::IDLE:
					strobe_seen <= change_instruction;
				ctrl_pkg::ARMED:
				begin
					if (clear_instruction)
						erase_flag <= 1'b1;
					if (issue)
						strobe_seen <= 1'b0;
					else if (change_instruction)
						strobe_seen <= 1'b1;
					if (issue && !erase_sel)
						last_shape <= shape_now;
				end
				ctrl_pkg::ERASE:
				begin
					strobe_seen <= 1'b0;
					if (cmd.done)
						erase_flag <= 1'b0;
				end
				default:
					strobe_seen <= 1'b0; // strobes during a draw are dropped
			endcase
		end
	end

endmodule

// ==== src/glyph_top.sv ====
// glyph drawing top, random glyph draw and erase driving a plot stream
`timescale 1ns/10ps
`include "glyph_consts.svh"

module glyph_top (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 change_instruction,
	input  logic                 clear_instruction,
	output logic [`X_W-1:0]      x,
	output logic [`Y_W-1:0]      y,
	output logic [`COLOUR_W-1:0] colour,
	output logic                 plot,
	output logic                 done_signal
);

	glyph_pkg::glyph_e shape_now;

	draw_cmd_if cmd ();

	instruction_picker i_picker (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.shape_now          (shape_now)
	);

	glyph_sequencer i_sequencer (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.shape_now          (shape_now),
		.cmd                (cmd.seq)
	);

	glyph_plotter i_plotter (
		.clk     (clk),
		.reset_n (reset_n),
		.cmd     (cmd.plot),
		.x       (x),
		.y       (y),
		.colour  (colour),
		.plot    (plot)
	);

	assign done_signal = cmd.done; // end of glyph, draw or erase

endmodule

// ==== src/instruction_picker.sv ====
// instruction picker, free running lfsr sampled on each change strobe
`timescale 1ns/10ps
`include "glyph_consts.svh"

module instruction_picker (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              change_instruction,
	output glyph_pkg::glyph_e shape_now
);

	logic [`RAND_W-1:0] lfsr;
	logic               change_q;
	logic               change_rise;

	assign change_rise = change_instruction & ~change_q;

	// fibonacci lfsr, taps on bits 3 and 2, period 15
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			lfsr <= `RAND_SEED;
		else
			lfsr <= {lfsr[`RAND_W-2:0], lfsr[3] ^ lfsr[2]};
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			change_q  <= 1'b0;
			shape_now <= glyph_pkg::UP;
		end
		else
		begin
			change_q <= change_instruction;
			if (change_rise)
			begin
				// uneven split, arrows come up more often than L and R
				if (lfsr < `RAND_W'd3)
					shape_now <= glyph_pkg::UP;
				else if (lfsr < `RAND_W'd6)
					shape_now <= glyph_pkg::DOWN;
				else if (lfsr < `RAND_W'd9)
					shape_now <= glyph_pkg::LEFT;
				else if (lfsr < `RAND_W'd11)
					shape_now <= glyph_pkg::RIGHT;
				else if (lfsr < `RAND_W'd13)
					shape_now <= glyph_pkg::L;
				else
					shape_now <= glyph_pkg::R;
			end
		end
	end

endmodule

// ==== verif/glyph_tb.sv ====
// glyph plotter testbench that checks random draw and erase runs against a table model
`timescale 1ns/10ps
`include "glyph_consts.svh"

module glyph_tb;

	localparam int WAIT_LIMIT = 64;  // clocks before any wait gives up
	localparam int MAX_GLYPHS = 400;

	logic                 clk;
	logic                 reset_n;
	logic                 change_instruction;
	logic                 clear_instruction;
	logic [`X_W-1:0]      x;
	logic [`Y_W-1:0]      y;
	logic [`COLOUR_W-1:0] colour;
	logic                 plot;
	logic                 done_signal;

	logic [15:0]          rnd;        // stimulus lfsr
	logic [`RAND_W-1:0]   pick_lfsr;  // mirror of the picker lfsr
	logic                 pick_chg_q;
	glyph_pkg::glyph_e    pick_shape;
	int                   exp_x[$];
	int                   exp_y[$];
	int                   drawn[6];
	int                   erased[6];

	glyph_top i_dut (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.x                  (x),
		.y                  (y),
		.colour             (colour),
		.plot               (plot),
		.done_signal        (done_signal)
	);

	always #4 clk = ~clk;

	function automatic glyph_pkg::glyph_e shape_for(input logic [`RAND_W-1:0] v);
		if (v < 3)
			return glyph_pkg::UP;
		else if (v < 6)
			return glyph_pkg::DOWN;
		else if (v < 9)
			return glyph_pkg::LEFT;
		else if (v < 11)
			return glyph_pkg::RIGHT;
		else if (v < 13)
			return glyph_pkg::L;
		return glyph_pkg::R;
	endfunction

	// picker model takes a shape on each rise of the change strobe
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			pick_lfsr  <= `RAND_SEED;
			pick_chg_q <= 1'b0;
			pick_shape <= glyph_pkg::UP;
		end
		else
		begin
			pick_lfsr  <= {pick_lfsr[2:0], pick_lfsr[3] ^ pick_lfsr[2]};
			pick_chg_q <= change_instruction;
			if (change_instruction && !pick_chg_q)
				pick_shape <= shape_for(pick_lfsr);
		end
	end

	function automatic logic [2:0] colour_for(input glyph_pkg::glyph_e s);
		case (s)
			glyph_pkg::UP:    return 3'b111;
			glyph_pkg::DOWN:  return 3'b001;
			glyph_pkg::RIGHT: return 3'b011;
			glyph_pkg::LEFT:  return 3'b010;
			glyph_pkg::L:     return 3'b101;
			default:          return 3'b100;
		endcase
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		repeat (n)
		begin
			rnd = lfsr_step(rnd);
			val = (val << 1) | int'(rnd[0]);
		end
	endtask

	function automatic int count_missing();
		int m;
		m = 0;
		for (int s = 0; s < 6; s++)
			if (drawn[s] == 0 || erased[s] == 0)
				m++;
		return m;
	endfunction

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic fail_value(input string msg);
		report_failure($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	task automatic add_stroke(input int ox, input int oy, input int sx, input int sy,
			input int n);
		for (int k = 0; k < n; k++)
		begin
			exp_x.push_back(`ORIGIN_X + ox + k * sx);
			exp_y.push_back(`ORIGIN_Y + oy + k * sy);
		end
	endtask

	// expected point order straight from the stroke table
	task automatic load_points(input glyph_pkg::glyph_e shape);
		exp_x.delete();
		exp_y.delete();
		case (shape)
			glyph_pkg::UP, glyph_pkg::DOWN:
			begin
				add_stroke(0, 0, 0, 1, 8);
				add_stroke(0, 0, 1, 1, 4);
				add_stroke(0, 0, -1, 1, 4);
			end
			glyph_pkg::RIGHT:
			begin
				add_stroke(0, 0, -1, 0, 8);
				add_stroke(0, 0, -1, -1, 4);
				add_stroke(0, 0, -1, 1, 4);
			end
			glyph_pkg::LEFT:
			begin
				add_stroke(0, 0, 1, 0, 8);
				add_stroke(0, 0, 1, -1, 4);
				add_stroke(0, 0, 1, 1, 4);
			end
			glyph_pkg::L:
			begin
				add_stroke(0, 0, 0, -1, 8);
				add_stroke(0, 0, 1, 0, 4);
			end
			default:
			begin
				add_stroke(0, 0, 1, 0, 4);
				add_stroke(2, 0, 1, 1, 3);
				add_stroke(3, 1, 0, 1, 4);
				add_stroke(3, 3, -1, 1, 3);
				add_stroke(2, 4, -1, 0, 4);
				add_stroke(0, 0, 0, 1, 5);
				add_stroke(0, 4, 0, 1, 5);
				add_stroke(0, 4, 1, 1, 5);
			end
		endcase
	endtask

	task automatic expect_quiet(input int n);
		repeat (n)
		begin
			@(posedge clk);
			assert (plot === 1'b0 && done_signal === 1'b0)
				else fail_value("plot or done_signal active while no glyph is due");
		end
	endtask

	task automatic pulse_change(input int width);
		change_instruction <= 1'b1;
		expect_quiet(width); // nothing plots before the strobe falls
		change_instruction <= 1'b0;
	endtask

	task automatic check_glyph(input glyph_pkg::glyph_e shape, input logic erase,
			input logic mid_strobe);
		logic [2:0] want;
		int         i;
		int         gap;
		load_points(shape);
		want = erase ? 3'b000 : colour_for(shape);
		for (i = 0; i < exp_x.size(); i++)
		begin
			gap = 0;
			do
			begin
				@(posedge clk);
				gap++;
				assert (done_signal === 1'b0)
					else fail_value($sformatf("done_signal before point %0d", i));
				if (gap > WAIT_LIMIT)
					report_failure($sformatf("no plot pulse came for point %0d", i));
			end
			while (plot !== 1'b1);
			if (i > 0)
			begin
				assert (gap == `GLYPH_STEP_CYCLES)
					else fail_value($sformatf("point %0d came %0d clocks after the last", i, gap));
			end
			assert (int'(x) == exp_x[i] && int'(y) == exp_y[i])
				else fail_value($sformatf("point %0d at (%0d,%0d), expected (%0d,%0d)",
					i, x, y, exp_x[i], exp_y[i]));
			assert (colour === want)
				else fail_value($sformatf("point %0d colour %b, expected %b", i, colour, want));
			if (mid_strobe)
				change_instruction <= (i == 1); // strobe while busy must be dropped
		end
		gap = 0;
		do
		begin
			@(posedge clk);
			gap++;
			assert (plot === 1'b0)
				else fail_value("plot pulse after the last point of the glyph");
			if (gap > WAIT_LIMIT)
				report_failure("done_signal never came after the last point");
		end
		while (done_signal !== 1'b1);
		assert (gap == 1)
			else fail_value($sformatf("done_signal %0d clocks after the last point", gap));
		@(posedge clk);
		assert (done_signal === 1'b0)
			else fail_value("done_signal high for more than one clock");
	endtask

	initial
	begin
		int                kind;
		int                width;
		int                gap;
		int                mid;
		int                n;
		logic              armed;
		logic              erase_next;
		glyph_pkg::glyph_e shape;
		glyph_pkg::glyph_e last_drawn;
		clk                = 1'b0;
		reset_n            = 1'b0;
		change_instruction = 1'b0;
		clear_instruction  = 1'b0;
		rnd                = 16'd53;
		armed              = 1'b0;
		erase_next         = 1'b0;
		last_drawn         = glyph_pkg::UP;
		n                  = 0;
		repeat (4)
			@(posedge clk);
		reset_n <= 1'b1;
		expect_quiet(12);
		while (count_missing() != 0 && n < MAX_GLYPHS)
		begin
			take_bits(1, kind);
			if (kind == 1)
			begin
				clear_instruction <= 1'b1;
				expect_quiet(1);
				clear_instruction <= 1'b0;
				erase_next = armed; // ignored unless a draw left the sequencer armed
				take_bits(3, gap);
				expect_quiet(gap + 2);
			end
			take_bits(2, width);
			take_bits(1, mid);
			pulse_change(width + 2);
			if (erase_next)
			begin
				check_glyph(last_drawn, 1'b1, mid == 1);
				erased[int'(last_drawn)]++;
				armed      = 1'b0;
				erase_next = 1'b0;
			end
			else
			begin
				shape = pick_shape;
				check_glyph(shape, 1'b0, mid == 1);
				drawn[int'(shape)]++;
				last_drawn = shape;
				armed      = 1'b1;
			end
			take_bits(4, gap);
			expect_quiet(gap + 6); // nothing until the next change strobe
			n++;
		end
		if (count_missing() == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
			report_failure("not every shape was drawn and erased within the glyph limit");
	end

endmodule
